//--- Makefile
SIM      = verilator
FLAGS    = --binary --timing -Wno-fatal
TOP      = fetchUnitTb
FILELIST = vlog.f
OBJDIR   = obj_dir
BIN      = $(OBJDIR)/V$(TOP)
SOURCES  = $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: run

$(BIN): $(SOURCES) $(FILELIST)
	$(SIM) $(FLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FILELIST)

run: $(BIN)
	@out="$$(./$(BIN))"; echo "$$out"; echo "$$out" | grep -q "Verification passed"

clean:
	rm -rf $(OBJDIR)

//--- hdl/branchPredictor.sv
`timescale 1ns/1ps

module branchPredictor (
  input  logic                            clk,
  input  logic                            reset,
  input  logic [fetchPkg::PcWidth-1:0]    pc_i,
  input  logic                            updateEn_i,
  input  logic [fetchPkg::PcWidth-1:0]    updatePc_i,
  input  logic                            updateDir_i,
  output logic [fetchPkg::FetchWidth-1:0] taken_o
);

  logic [1:0]                      ctrArr [fetchPkg::BpEntries]; // 2-bit direction counters
  logic [fetchPkg::BpIdxWidth-1:0] updIdx;
  logic [1:0]                      updCtr;

  assign updIdx = updatePc_i[2 +: fetchPkg::BpIdxWidth];
  assign updCtr = ctrArr[updIdx];

  always_comb begin
    logic [fetchPkg::PcWidth-1:0]    slotPc;
    logic [fetchPkg::BpIdxWidth-1:0] idx;
    for (int k = 0; k < fetchPkg::FetchWidth; k++) begin
      slotPc     = {pc_i[fetchPkg::PcWidth-1:fetchPkg::OffsetWidth],
                    {fetchPkg::OffsetWidth{1'b0}}} + 4 * k;
      idx        = slotPc[2 +: fetchPkg::BpIdxWidth];
      taken_o[k] = ctrArr[idx][1];                             // Upper half means taken
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      for (int i = 0; i < fetchPkg::BpEntries; i++) begin
        ctrArr[i] <= 2'b01;                                    // Weakly not-taken
      end
    end else if (updateEn_i) begin
      if (updateDir_i && updCtr != 2'b11) begin
        ctrArr[updIdx] <= updCtr + 2'b01;                      // Saturate at strongly taken
      end else if (!updateDir_i && updCtr != 2'b00) begin
        ctrArr[updIdx] <= updCtr - 2'b01;
      end
    end
  end

endmodule

//--- hdl/branchTargetBuffer.sv
`timescale 1ns/1ps

module branchTargetBuffer (
  input  logic                            clk,
  input  logic                            reset,
  input  logic [fetchPkg::PcWidth-1:0]    pc_i,
  input  logic                            updateEn_i,
  input  logic [fetchPkg::PcWidth-1:0]    updatePc_i,
  input  fetchPkg::brType_e               updateType_i,
  input  logic [fetchPkg::PcWidth-1:0]    updateTarget_i,
  output logic [fetchPkg::FetchWidth-1:0] hit_o,
  output fetchPkg::brType_e               type0_o,
  output fetchPkg::brType_e               type1_o,
  output fetchPkg::brType_e               type2_o,
  output fetchPkg::brType_e               type3_o,
  output logic [fetchPkg::PcWidth-1:0]    target0_o,
  output logic [fetchPkg::PcWidth-1:0]    target1_o,
  output logic [fetchPkg::PcWidth-1:0]    target2_o,
  output logic [fetchPkg::PcWidth-1:0]    target3_o
);

  logic                             validArr  [fetchPkg::BtbEntries];
  logic [fetchPkg::BtbTagWidth-1:0] tagArr    [fetchPkg::BtbEntries];
  fetchPkg::brType_e                typeArr   [fetchPkg::BtbEntries];
  logic [fetchPkg::PcWidth-1:0]     targetArr [fetchPkg::BtbEntries];

  fetchPkg::brType_e                slotType   [fetchPkg::FetchWidth];
  logic [fetchPkg::PcWidth-1:0]     slotTarget [fetchPkg::FetchWidth];
  logic [fetchPkg::PcWidth-1:0]     groupBase;
  logic [fetchPkg::BtbIdxWidth-1:0] updIdx;

  assign groupBase = {pc_i[fetchPkg::PcWidth-1:fetchPkg::OffsetWidth],
                      {fetchPkg::OffsetWidth{1'b0}}};          // Aligned group start
  assign updIdx    = updatePc_i[2 +: fetchPkg::BtbIdxWidth];   // Word index of the branch

  always_comb begin
    logic [fetchPkg::PcWidth-1:0]     slotPc;
    logic [fetchPkg::BtbIdxWidth-1:0] idx;
    for (int k = 0; k < fetchPkg::FetchWidth; k++) begin
      slotPc        = groupBase + 4 * k;                       // Slot k word address
      idx           = slotPc[2 +: fetchPkg::BtbIdxWidth];
      hit_o[k]      = validArr[idx] &&
                      (tagArr[idx] == slotPc[fetchPkg::PcWidth-1 -: fetchPkg::BtbTagWidth]);
      slotType[k]   = typeArr[idx];
      slotTarget[k] = targetArr[idx];
    end
  end

  assign type0_o   = slotType[0];
  assign type1_o   = slotType[1];
  assign type2_o   = slotType[2];
  assign type3_o   = slotType[3];
  assign target0_o = slotTarget[0];
  assign target1_o = slotTarget[1];
  assign target2_o = slotTarget[2];
  assign target3_o = slotTarget[3];

  always_ff @(posedge clk) begin
    if (reset) begin
      for (int i = 0; i < fetchPkg::BtbEntries; i++) begin
        validArr[i] <= 1'b0;                                   // Empty after reset
      end
    end else if (updateEn_i) begin
      validArr[updIdx] <= 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (updateEn_i) begin
      tagArr[updIdx]    <= updatePc_i[fetchPkg::PcWidth-1 -: fetchPkg::BtbTagWidth];
      typeArr[updIdx]   <= updateType_i;
      targetArr[updIdx] <= updateTarget_i;
    end
  end

endmodule

//--- hdl/fetchPkg.sv
package fetchPkg;

  // ----------------------------------------------------------------------
  // Datapath widths
  // ----------------------------------------------------------------------
  localparam int PcWidth     = 32;                     // Byte address
  localparam int InstWidth   = 32;                     // One instruction word
  localparam int FetchWidth  = 4;                      // Slots per fetch group
  localparam int BundleWidth = FetchWidth * InstWidth; // 128-bit group
  localparam int GroupBytes  = 16;                     // Byte stride of a group
  localparam int OffsetWidth = $clog2(GroupBytes);     // Byte offset inside a group
  localparam int SlotWidth   = $clog2(FetchWidth);     // Slot number inside a group

  // ----------------------------------------------------------------------
  // Table geometry
  // ----------------------------------------------------------------------
  localparam int CacheLines    = 16;                   // One group per line
  localparam int CacheIdxWidth = $clog2(CacheLines);   // Group bits 7..4
  localparam int CacheTagWidth = PcWidth - CacheIdxWidth - OffsetWidth;
  localparam int BtbEntries    = 64;                   // Word bits 7..2
  localparam int BtbIdxWidth   = $clog2(BtbEntries);
  localparam int BtbTagWidth   = PcWidth - BtbIdxWidth - 2;
  localparam int BpEntries     = 256;                  // Word bits 9..2
  localparam int BpIdxWidth    = $clog2(BpEntries);
  localparam int RasDepth      = 8;
  localparam int RasPtrWidth   = $clog2(RasDepth);

  // Control-transfer types in the retire-side CTI queue encoding
  typedef enum logic [1:0] {
    BrReturn = 2'd0,
    BrCall   = 2'd1,
    BrJump   = 2'd2,
    BrCond   = 2'd3
  } brType_e;

endpackage

//--- hdl/fetchStage1.sv
`timescale 1ns/1ps

module fetchStage1 (
  input  logic                             clk,
  input  logic                             reset,
  input  logic                             stall_i,
  input  logic                             recover_i,
  input  logic [fetchPkg::PcWidth-1:0]     recoverPc_i,
  input  logic                             updateEn_i,
  input  logic [fetchPkg::PcWidth-1:0]     updatePc_i,
  input  logic [fetchPkg::PcWidth-1:0]     updateTarget_i,
  input  fetchPkg::brType_e                updateType_i,
  input  logic                             updateDir_i,
  input  logic                             wrEnable_i,
  input  logic [fetchPkg::PcWidth-1:0]     wrAddr_i,
  input  logic [fetchPkg::BundleWidth-1:0] block_i,
  output logic                             groupValid_o,
  output logic [fetchPkg::PcWidth-1:0]     groupPc_o,
  output logic [fetchPkg::BundleWidth-1:0] bundle_o,
  output logic [fetchPkg::FetchWidth-1:0]  slotValid_o,
  output logic [fetchPkg::PcWidth-1:0]     predNextPc_o,
  output logic                             miss_o,
  output logic [fetchPkg::PcWidth-1:0]     missAddr_o
);

  logic [fetchPkg::PcWidth-1:0]    pc;                         // Fetch PC register
  logic [fetchPkg::PcWidth-1:0]    groupBase;
  logic [fetchPkg::PcWidth-1:0]    predPc;
  logic [fetchPkg::PcWidth-1:0]    nextPc;
  logic [fetchPkg::PcWidth-1:0]    rasTop;
  logic [fetchPkg::PcWidth-1:0]    pushAddr;
  logic [fetchPkg::SlotWidth-1:0]  pcSlot;
  logic [fetchPkg::FetchWidth-1:0] btbHit;
  logic [fetchPkg::FetchWidth-1:0] bpTaken;
  fetchPkg::brType_e               slotType   [fetchPkg::FetchWidth];
  logic [fetchPkg::PcWidth-1:0]    slotTarget [fetchPkg::FetchWidth];
  logic btbWe, bpWe, advance, push, pop;

  assign groupBase = {pc[fetchPkg::PcWidth-1:fetchPkg::OffsetWidth],
                      {fetchPkg::OffsetWidth{1'b0}}};
  assign pcSlot    = pc[2 +: fetchPkg::SlotWidth];            // First live slot
  assign advance   = !stall_i && !miss_o && !recover_i;       // Group moves to stage 2

  // Conditionals only write the BTB when taken
  assign btbWe = updateEn_i && (updateType_i != fetchPkg::BrCond || updateDir_i);
  assign bpWe  = updateEn_i && updateType_i == fetchPkg::BrCond;

  // ----------------------------------------------------------------------
  // Lookup blocks
  // ----------------------------------------------------------------------
  branchTargetBuffer u_btb (
    .clk(clk), .reset(reset), .pc_i(pc),
    .updateEn_i(btbWe), .updatePc_i(updatePc_i), .updateType_i(updateType_i),
    .updateTarget_i(updateTarget_i), .hit_o(btbHit),
    .type0_o(slotType[0]), .type1_o(slotType[1]),
    .type2_o(slotType[2]), .type3_o(slotType[3]),
    .target0_o(slotTarget[0]), .target1_o(slotTarget[1]),
    .target2_o(slotTarget[2]), .target3_o(slotTarget[3])
  );

  branchPredictor u_bp (
    .clk(clk), .reset(reset), .pc_i(pc), .updateEn_i(bpWe),
    .updatePc_i(updatePc_i), .updateDir_i(updateDir_i), .taken_o(bpTaken)
  );

  returnAddressStack u_ras (
    .clk(clk), .reset(reset), .push_i(push && advance), .pushAddr_i(pushAddr),
    .pop_i(pop && advance), .top_o(rasTop)
  );

  instCache u_icache (
    .clk(clk), .reset(reset), .pc_i(pc), .wrEnable_i(wrEnable_i),
    .wrAddr_i(wrAddr_i), .block_i(block_i), .bundle_o(bundle_o),
    .miss_o(miss_o), .missAddr_o(missAddr_o)
  );

  // ----------------------------------------------------------------------
  // Slot mask, first taken slot and RAS control
  // ----------------------------------------------------------------------
  always_comb begin
    logic seen;
    logic taken;
    seen     = 1'b0;
    predPc   = groupBase + fetchPkg::GroupBytes;              // Sequential by default
    push     = 1'b0;
    pop      = 1'b0;
    pushAddr = groupBase;
    for (int k = 0; k < fetchPkg::FetchWidth; k++) begin
      taken = (k >= pcSlot) && btbHit[k] &&
              (slotType[k] != fetchPkg::BrCond || bpTaken[k]);
      slotValid_o[k] = (k >= pcSlot) && !seen;                // Dead after the taken slot
      if (taken && !seen) begin
        seen     = 1'b1;
        predPc   = (slotType[k] == fetchPkg::BrReturn) ? rasTop : slotTarget[k];
        push     = slotType[k] == fetchPkg::BrCall;
        pop      = slotType[k] == fetchPkg::BrReturn;
        pushAddr = groupBase + 4 * (k + 1);                   // Return lands after the call
      end
    end
  end

  assign nextPc       = recover_i ? recoverPc_i : predPc;      // Recovery wins
  assign groupValid_o = advance;
  assign groupPc_o    = groupBase;
  assign predNextPc_o = predPc;

  always_ff @(posedge clk) begin
    if (reset) begin
      pc <= '0;
    end else if (recover_i || (!stall_i && !miss_o)) begin
      pc <= nextPc;                                            // Hold on stall or miss
    end
  end

endmodule

//--- hdl/fetchStage2.sv
`timescale 1ns/1ps

module fetchStage2 (
  input  logic                             clk,
  input  logic                             reset,
  input  logic                             stall_i,
  input  logic                             valid_i,
  input  logic [fetchPkg::PcWidth-1:0]     pc_i,
  input  logic [fetchPkg::BundleWidth-1:0] bundle_i,
  input  logic [fetchPkg::FetchWidth-1:0]  slotValid_i,
  input  logic [fetchPkg::PcWidth-1:0]     predNextPc_i,
  output logic                             fetchValid_o,
  output logic [fetchPkg::PcWidth-1:0]     fetchPc_o,
  output logic [fetchPkg::BundleWidth-1:0] bundle_o,
  output logic [fetchPkg::FetchWidth-1:0]  slotValid_o,
  output logic [fetchPkg::PcWidth-1:0]     predNextPc_o
);

  always_ff @(posedge clk) begin
    if (reset) begin
      fetchValid_o <= 1'b0;
    end else if (!stall_i) begin
      fetchValid_o <= valid_i;                                 // Bubble on miss or recovery
    end
  end

  // Payload follows the valid bit and freezes with it
  always_ff @(posedge clk) begin
    if (!stall_i) begin
      fetchPc_o    <= pc_i;
      bundle_o     <= bundle_i;
      slotValid_o  <= slotValid_i;
      predNextPc_o <= predNextPc_i;
    end
  end

endmodule

//--- hdl/fetchUnit.sv
`timescale 1ns/1ps

module fetchUnit (
  input  logic                             clk,
  input  logic                             reset,
  input  logic                             stall_i,
  input  logic                             recover_i,
  input  logic [fetchPkg::PcWidth-1:0]     recoverPc_i,
  input  logic                             updateEn_i,
  input  logic [fetchPkg::PcWidth-1:0]     updatePc_i,
  input  logic [fetchPkg::PcWidth-1:0]     updateTarget_i,
  input  fetchPkg::brType_e                updateType_i,
  input  logic                             updateDir_i,
  input  logic                             wrEnable_i,
  input  logic [fetchPkg::PcWidth-1:0]     wrAddr_i,
  input  logic [fetchPkg::BundleWidth-1:0] block_i,
  output logic                             fetchValid_o,
  output logic [fetchPkg::PcWidth-1:0]     fetchPc_o,
  output logic [fetchPkg::BundleWidth-1:0] bundle_o,
  output logic [fetchPkg::FetchWidth-1:0]  slotValid_o,
  output logic [fetchPkg::PcWidth-1:0]     predNextPc_o,
  output logic                             miss_o,
  output logic [fetchPkg::PcWidth-1:0]     missAddr_o
);

  logic                             s1Valid;                   // Stage 1 to stage 2 group
  logic [fetchPkg::PcWidth-1:0]     s1Pc;
  logic [fetchPkg::BundleWidth-1:0] s1Bundle;
  logic [fetchPkg::FetchWidth-1:0]  s1SlotValid;
  logic [fetchPkg::PcWidth-1:0]     s1PredNextPc;

  fetchStage1 u_fetchStage1 (
    .clk(clk), .reset(reset), .stall_i(stall_i),
    .recover_i(recover_i), .recoverPc_i(recoverPc_i),
    .updateEn_i(updateEn_i), .updatePc_i(updatePc_i), .updateTarget_i(updateTarget_i),
    .updateType_i(updateType_i), .updateDir_i(updateDir_i),
    .wrEnable_i(wrEnable_i), .wrAddr_i(wrAddr_i), .block_i(block_i),
    .groupValid_o(s1Valid), .groupPc_o(s1Pc), .bundle_o(s1Bundle),
    .slotValid_o(s1SlotValid), .predNextPc_o(s1PredNextPc),
    .miss_o(miss_o), .missAddr_o(missAddr_o)
  );

  fetchStage2 u_fetchStage2 (
    .clk(clk), .reset(reset), .stall_i(stall_i),
    .valid_i(s1Valid), .pc_i(s1Pc), .bundle_i(s1Bundle),
    .slotValid_i(s1SlotValid), .predNextPc_i(s1PredNextPc),
    .fetchValid_o(fetchValid_o), .fetchPc_o(fetchPc_o), .bundle_o(bundle_o),
    .slotValid_o(slotValid_o), .predNextPc_o(predNextPc_o)
  );

endmodule

//--- hdl/instCache.sv
`timescale 1ns/1ps

module instCache (
  input  logic                             clk,
  input  logic                             reset,
  input  logic [fetchPkg::PcWidth-1:0]     pc_i,
  input  logic                             wrEnable_i,
  input  logic [fetchPkg::PcWidth-1:0]     wrAddr_i,
  input  logic [fetchPkg::BundleWidth-1:0] block_i,
  output logic [fetchPkg::BundleWidth-1:0] bundle_o,
  output logic                             miss_o,
  output logic [fetchPkg::PcWidth-1:0]     missAddr_o
);

  logic                               validArr [fetchPkg::CacheLines];
  logic [fetchPkg::CacheTagWidth-1:0] tagArr   [fetchPkg::CacheLines];
  logic [fetchPkg::BundleWidth-1:0]   dataArr  [fetchPkg::CacheLines];

  logic [fetchPkg::CacheIdxWidth-1:0] rdIdx;
  logic [fetchPkg::CacheIdxWidth-1:0] wrIdx;
  logic [fetchPkg::CacheTagWidth-1:0] rdTag;

  assign rdIdx = pc_i[fetchPkg::OffsetWidth +: fetchPkg::CacheIdxWidth];
  assign wrIdx = wrAddr_i[fetchPkg::OffsetWidth +: fetchPkg::CacheIdxWidth];
  assign rdTag = pc_i[fetchPkg::PcWidth-1 -: fetchPkg::CacheTagWidth];

  // ----------------------------------------------------------------------
  // Lookup
  // ----------------------------------------------------------------------
  assign bundle_o   = dataArr[rdIdx];                          // Whole line is the group
  assign miss_o     = !(validArr[rdIdx] && tagArr[rdIdx] == rdTag);
  assign missAddr_o = {pc_i[fetchPkg::PcWidth-1:fetchPkg::OffsetWidth],
                       {fetchPkg::OffsetWidth{1'b0}}};        // Block-aligned request

  // ----------------------------------------------------------------------
  // Refill
  // ----------------------------------------------------------------------
  always_ff @(posedge clk) begin
    if (reset) begin
      for (int i = 0; i < fetchPkg::CacheLines; i++) begin
        validArr[i] <= 1'b0;
      end
    end else if (wrEnable_i) begin
      validArr[wrIdx] <= 1'b1;                                 // Miss clears next cycle
    end
  end

  always_ff @(posedge clk) begin
    if (wrEnable_i) begin
      tagArr[wrIdx]  <= wrAddr_i[fetchPkg::PcWidth-1 -: fetchPkg::CacheTagWidth];
      dataArr[wrIdx] <= block_i;
    end
  end

endmodule

//--- hdl/returnAddressStack.sv
`timescale 1ns/1ps

module returnAddressStack (
  input  logic                         clk,
  input  logic                         reset,
  input  logic                         push_i,
  input  logic [fetchPkg::PcWidth-1:0] pushAddr_i,
  input  logic                         pop_i,
  output logic [fetchPkg::PcWidth-1:0] top_o
);

  logic [fetchPkg::PcWidth-1:0]     stackArr [fetchPkg::RasDepth];
  logic [fetchPkg::RasPtrWidth-1:0] ptr;                       // Points at the top entry
  logic [fetchPkg::RasPtrWidth-1:0] ptrInc;

  assign ptrInc = ptr + 1'b1;                                  // Wraps on overflow
  assign top_o  = stackArr[ptr];

  always_ff @(posedge clk) begin
    if (reset) begin
      ptr <= '0;
    end else if (push_i) begin
      ptr <= ptrInc;
    end else if (pop_i) begin
      ptr <= ptr - 1'b1;
    end
  end

  // Oldest entry is overwritten once the pointer wraps
  always_ff @(posedge clk) begin
    if (push_i) begin
      stackArr[ptrInc] <= pushAddr_i;
    end
  end

endmodule

//--- tb/fetchUnitTb.sv
`timescale 1ns/1ps

module fetchUnitTb;

  logic                             clk;
  logic                             reset;
  logic                             stall;
  logic                             recover;
  logic [fetchPkg::PcWidth-1:0]     recoverPc;
  logic                             updateEn;
  logic [fetchPkg::PcWidth-1:0]     updatePc;
  logic [fetchPkg::PcWidth-1:0]     updateTarget;
  fetchPkg::brType_e                updateType;
  logic                             updateDir;
  logic                             wrEnable;
  logic [fetchPkg::PcWidth-1:0]     wrAddr;
  logic [fetchPkg::BundleWidth-1:0] refillBlock;
  logic                             fetchValid;
  logic [fetchPkg::PcWidth-1:0]     fetchPc;
  logic [fetchPkg::BundleWidth-1:0] bundle;
  logic [fetchPkg::FetchWidth-1:0]  slotValid;
  logic [fetchPkg::PcWidth-1:0]     predNextPc;
  logic                             miss;
  logic [fetchPkg::PcWidth-1:0]     missAddr;

  int                               errorCount;
  int                               checkCount;
  int                               testCount;
  int                               testErrBase;               // Errors before current test
  logic [31:0]                      lfsrState;
  logic [fetchPkg::InstWidth-1:0]   wordKey;                   // Scrambles the memory image

  fetchUnit u_fetchUnit (
    .clk(clk), .reset(reset), .stall_i(stall),
    .recover_i(recover), .recoverPc_i(recoverPc),
    .updateEn_i(updateEn), .updatePc_i(updatePc), .updateTarget_i(updateTarget),
    .updateType_i(updateType), .updateDir_i(updateDir),
    .wrEnable_i(wrEnable), .wrAddr_i(wrAddr), .block_i(refillBlock),
    .fetchValid_o(fetchValid), .fetchPc_o(fetchPc), .bundle_o(bundle),
    .slotValid_o(slotValid), .predNextPc_o(predNextPc),
    .miss_o(miss), .missAddr_o(missAddr)
  );

  always #2 clk = ~clk;                                        // 4 ns period

  // ----------------------------------------------------------------------
  // Memory model
  // ----------------------------------------------------------------------
  function automatic logic [31:0] lfsrNext(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);       // Galois taps x^32+x^22+x^2+x+1
  endfunction

  task automatic drawKey();
    for (int i = 0; i < fetchPkg::InstWidth; i++) begin
      wordKey[i] = lfsrState[0];                               // One step per bit
      lfsrState  = lfsrNext(lfsrState);
    end
  endtask

  // Word at each address is its own address XORed with the key
  function automatic logic [fetchPkg::BundleWidth-1:0] modelBlock(
      input logic [fetchPkg::PcWidth-1:0] base);
    logic [fetchPkg::BundleWidth-1:0] blk;
    for (int k = 0; k < fetchPkg::FetchWidth; k++) begin
      blk[k*fetchPkg::InstWidth +: fetchPkg::InstWidth] = (base + 4 * k) ^ wordKey;
    end
    return blk;
  endfunction

  task automatic stepCycle();
    @(posedge clk);
    #0.5;                                                      // Drive and sample point
  endtask

  // ----------------------------------------------------------------------
  // Compare tasks
  // ----------------------------------------------------------------------
  task automatic checkPc(input string what, input logic [fetchPkg::PcWidth-1:0] got,
                         input logic [fetchPkg::PcWidth-1:0] expected);
    checkCount++;
    if (got !== expected) begin
      errorCount++;
      $display("Fail at %0t: %s is %h, expected %h", $time, what, got, expected);
    end
  endtask

  task automatic checkBundle(input string what, input logic [fetchPkg::BundleWidth-1:0] got,
                             input logic [fetchPkg::BundleWidth-1:0] expected);
    checkCount++;
    if (got !== expected) begin
      errorCount++;
      $display("Fail at %0t: %s is %h, expected %h", $time, what, got, expected);
    end
  endtask

  task automatic checkMask(input string what, input logic [fetchPkg::FetchWidth-1:0] got,
                           input logic [fetchPkg::FetchWidth-1:0] expected);
    checkCount++;
    if (got !== expected) begin
      errorCount++;
      $display("Fail at %0t: %s is %b, expected %b", $time, what, got, expected);
    end
  endtask

  task automatic checkFlag(input string what, input logic got, input logic expected);
    checkCount++;
    if (got !== expected) begin
      errorCount++;
      $display("Fail at %0t: %s is %b, expected %b", $time, what, got, expected);
    end
  endtask

  // ----------------------------------------------------------------------
  // Refill responder, waits and drivers
  // ----------------------------------------------------------------------
  task automatic serveMiss();
    int waited;
    waited = 0;
    while (!miss && waited < 40) begin
      stepCycle();
      waited++;
    end
    if (!miss) begin
      errorCount++;
      $display("Timeout at %0t: the cache never requested a refill", $time);
    end else begin
      wrEnable    = 1'b1;                                      // One-cycle refill strobe
      wrAddr      = missAddr;
      refillBlock = modelBlock(missAddr);
      stepCycle();
      wrEnable    = 1'b0;
    end
  endtask

  task automatic waitValid();
    int waited;
    waited = 0;
    while (!fetchValid && waited < 40) begin
      if (miss) begin
        serveMiss();
      end else begin
        stepCycle();
      end
      waited++;
    end
    if (!fetchValid) begin
      errorCount++;
      $display("Timeout at %0t: no valid fetch group arrived", $time);
    end
  endtask

  // Takes the next valid group and moves one cycle past it
  task automatic expectGroup(input logic [fetchPkg::PcWidth-1:0] base,
                             input logic [fetchPkg::FetchWidth-1:0] mask,
                             input logic [fetchPkg::PcWidth-1:0] nextPc);
    waitValid();
    checkPc("fetchPc_o", fetchPc, base);
    checkBundle("bundle_o", bundle, modelBlock(base));
    checkMask("slotValid_o", slotValid, mask);
    checkPc("predNextPc_o", predNextPc, nextPc);
    stepCycle();
  endtask

  task automatic recoverTo(input logic [fetchPkg::PcWidth-1:0] addr);
    recover   = 1'b1;
    recoverPc = addr;
    stepCycle();
    recover   = 1'b0;                                          // Stage 2 now holds a bubble
  endtask

  task automatic trainBranch(input logic [fetchPkg::PcWidth-1:0] pc,
                             input logic [fetchPkg::PcWidth-1:0] target,
                             input fetchPkg::brType_e kind, input logic dir);
    updateEn     = 1'b1;
    updatePc     = pc;
    updateTarget = target;
    updateType   = kind;
    updateDir    = dir;
    stepCycle();
    updateEn     = 1'b0;
  endtask

  task automatic finishTest(input string name);
    testCount++;
    if (errorCount == testErrBase) begin
      $display("Test %s: ok", name);
    end else begin
      $display("Test %s: %0d errors", name, errorCount - testErrBase);
    end
    testErrBase = errorCount;
  endtask

  // ----------------------------------------------------------------------
  // Tests
  // ----------------------------------------------------------------------
  task automatic coldFetch();
    checkFlag("miss_o", miss, 1'b1);                           // Cache is empty
    checkPc("missAddr_o", missAddr, 32'h0);
    serveMiss();
    for (int g = 0; g < 4; g++) begin
      expectGroup(16 * g, 4'b1111, 16 * g + 16);
    end
    finishTest("cold fetch");
  endtask

  task automatic recoverMidGroup();
    recoverTo(32'h108);
    checkFlag("miss_o", miss, 1'b1);                           // Line 0 still holds group 0
    checkPc("missAddr_o", missAddr, 32'h100);                  // Request is the group base
    expectGroup(32'h100, 4'b1100, 32'h110);                    // Slots 0 and 1 below the PC
    finishTest("recovery into mid-group");
  endtask

  task automatic jumpRedirect();
    trainBranch(32'h204, 32'h300, fetchPkg::BrJump, 1'b1);
    recoverTo(32'h200);
    expectGroup(32'h200, 4'b0011, 32'h300);                    // Slots after the jump cleared
    expectGroup(32'h300, 4'b1111, 32'h310);
    finishTest("unconditional jump");
  endtask

  task automatic condTraining();
    recoverTo(32'h400);
    expectGroup(32'h400, 4'b1111, 32'h410);                    // Unknown branch falls through
    repeat (2) trainBranch(32'h40C, 32'h480, fetchPkg::BrCond, 1'b1);
    recoverTo(32'h400);
    expectGroup(32'h400, 4'b1111, 32'h480);                    // Counter 01 to 11
    repeat (3) trainBranch(32'h40C, 32'h480, fetchPkg::BrCond, 1'b0);
    recoverTo(32'h400);
    expectGroup(32'h400, 4'b1111, 32'h410);                    // Counter back to 00
    finishTest("conditional training");
  endtask

  task automatic callReturn();
    trainBranch(32'h500, 32'h600, fetchPkg::BrCall, 1'b1);
    trainBranch(32'h608, 32'h000, fetchPkg::BrReturn, 1'b1);
    recoverTo(32'h500);
    expectGroup(32'h500, 4'b0001, 32'h600);                    // Call pushes 0x504
    expectGroup(32'h600, 4'b0111, 32'h504);                    // Return takes the RAS top
    expectGroup(32'h500, 4'b1110, 32'h510);
    finishTest("call and return");
  endtask

  task automatic stallHold();
    recoverTo(32'h000);
    expectGroup(32'h000, 4'b1111, 32'h010);
    stall = 1'b1;                                              // Group 0x010 sits in stage 2
    for (int c = 0; c < 5; c++) begin
      checkFlag("fetchValid_o", fetchValid, 1'b1);
      checkPc("fetchPc_o", fetchPc, 32'h010);
      checkBundle("bundle_o", bundle, modelBlock(32'h010));
      stepCycle();
    end
    stall = 1'b0;
    stepCycle();
    expectGroup(32'h020, 4'b1111, 32'h030);                    // Nothing lost across the stall
    expectGroup(32'h030, 4'b1111, 32'h040);
    finishTest("stall hold");
  endtask

  // ----------------------------------------------------------------------
  // Main sequence
  // ----------------------------------------------------------------------
  initial begin
    clk          = 1'b0;
    reset        = 1'b1;
    stall        = 1'b0;
    recover      = 1'b0;
    recoverPc    = '0;
    updateEn     = 1'b0;
    updatePc     = '0;
    updateTarget = '0;
    updateType   = fetchPkg::BrReturn;
    updateDir    = 1'b0;
    wrEnable     = 1'b0;
    wrAddr       = '0;
    refillBlock  = '0;
    errorCount   = 0;
    checkCount   = 0;
    testCount    = 0;
    testErrBase  = 0;
    lfsrState    = 32'd86;                                     // Fixed seed
    drawKey();
    repeat (5) @(posedge clk);
    #0.5;
    reset = 1'b0;
    coldFetch();
    recoverMidGroup();
    jumpRedirect();
    condTraining();
    callReturn();
    stallHold();
    $display("Tests %0d, checks %0d, errors %0d", testCount, checkCount, errorCount);
    if (errorCount == 0) begin
      $display("Verification passed");
    end else begin
      $display("Verification failed");
    end
    $finish;
  end

endmodule

//--- vlog.f
hdl/fetchPkg.sv
hdl/branchTargetBuffer.sv
hdl/branchPredictor.sv
hdl/returnAddressStack.sv
hdl/instCache.sv
hdl/fetchStage1.sv
hdl/fetchStage2.sv
hdl/fetchUnit.sv
tb/fetchUnitTb.sv
